// ==== src/field_defs.svh ====
//----------------------------------------------------------
// shared constants for the prime-field controller
// word width, modulus, microprogram geometry, pacing and
// the byte offsets of the AXI4-Lite register map
//----------------------------------------------------------
`ifndef FIELD_DEFS_SVH
`define FIELD_DEFS_SVH

// datapath
`define FIELD_W         32
`define FIELD_P         32'hFFFFFFFB

// microprogram and operand store geometry
`define UPROG_ADDR_W    5
`define UPROG_LINE_W    16
`define OPR_ADDR_W      3
`define STEP_CYCLES     4

// register map, byte offsets
`define REG_NAME        32'h00
`define REG_CTRL        32'h04
`define REG_STATUS      32'h08
`define REG_OP_A        32'h0C
`define REG_OP_B        32'h10
`define REG_OP_C        32'h14
`define REG_RESULT      32'h18

// reads back as "FP32"
`define CORE_NAME       32'h46503332

`endif

// ==== src/field_pkg.sv ====
//----------------------------------------------------------
// types shared by the ROM, sequencer, arithmetic unit and
// register bank, plus the micro-instruction layout
//----------------------------------------------------------
`include "field_defs.svh"

package field_pkg;

    typedef enum logic [2:0] {NOP, WR_CORE, ARITH, RD_CORE, END} uop_e;
    typedef enum logic [1:0] {CMD_NONE, CMD_MULADD, CMD_SQRSUB} cmd_e;
    typedef enum logic [1:0] {OP_LOAD, OP_ADD, OP_SUB, OP_MUL} arith_op_e;
    typedef enum logic [2:0] {SRC_A, SRC_B, SRC_C, SRC_ZERO, SRC_ONE} src_e;

    // line layout: uop | op | dst | src_a | src_b | spare
    localparam int LN_UOP = 13;
    localparam int LN_OP  = 11;
    localparam int LN_DST = 8;
    localparam int LN_SA  = 5;
    localparam int LN_SB  = 2;

    // program entry points in the ROM
    localparam logic [`UPROG_ADDR_W-1:0] UPROG_IDLE   = 5'd0;
    localparam logic [`UPROG_ADDR_W-1:0] MULADD_START = 5'd1;
    localparam logic [`UPROG_ADDR_W-1:0] SQRSUB_START = 5'd8;

    // packs one micro-instruction, a WR_CORE line carries src_e in sa
    function automatic logic [`UPROG_LINE_W-1:0] uline(
        input uop_e                   uop,
        input arith_op_e              op,
        input logic [`OPR_ADDR_W-1:0] dst,
        input logic [`OPR_ADDR_W-1:0] sa,
        input logic [`OPR_ADDR_W-1:0] sb
    );
        return {uop, op, dst, sa, sb, 2'b00};
    endfunction

endpackage

// ==== src/field_uprog_rom.sv ====
//----------------------------------------------------------
// microprogram ROM, one registered read per cycle
// line_o follows addr_i by one clock; address 0 is the
// idle line and unused addresses read as NOP
//----------------------------------------------------------
`timescale 1ns/1ps
`include "field_defs.svh"

module field_uprog_rom (
    input  logic                     clk,
    input  logic                     reset_n,
    input  logic [`UPROG_ADDR_W-1:0] addr_i,
    output logic [`UPROG_LINE_W-1:0] line_o
);
    import field_pkg::*;

    logic [`UPROG_LINE_W-1:0] rom_line;

    always_comb begin
        case (addr_i)
            // MULADD: r4 = r0*r1 + r2
            5'd1:    rom_line = uline(WR_CORE, OP_LOAD, 3'd0, SRC_A, 3'd0);
            5'd2:    rom_line = uline(WR_CORE, OP_LOAD, 3'd1, SRC_B, 3'd0);
            5'd3:    rom_line = uline(WR_CORE, OP_LOAD, 3'd2, SRC_C, 3'd0);
            5'd4:    rom_line = uline(ARITH,   OP_MUL,  3'd3, 3'd0,  3'd1);
            5'd5:    rom_line = uline(ARITH,   OP_ADD,  3'd4, 3'd3,  3'd2);
            5'd6:    rom_line = uline(RD_CORE, OP_LOAD, 3'd0, 3'd4,  3'd0);
            5'd7:    rom_line = uline(END,     OP_LOAD, 3'd0, 3'd0,  3'd0);
            // SQRSUB: r3 = r0*r0 - r1
            5'd8:    rom_line = uline(WR_CORE, OP_LOAD, 3'd0, SRC_A, 3'd0);
            5'd9:    rom_line = uline(WR_CORE, OP_LOAD, 3'd1, SRC_B, 3'd0);
            5'd10:   rom_line = uline(ARITH,   OP_MUL,  3'd2, 3'd0,  3'd0);
            5'd11:   rom_line = uline(ARITH,   OP_SUB,  3'd3, 3'd2,  3'd1);
            5'd12:   rom_line = uline(RD_CORE, OP_LOAD, 3'd0, 3'd3,  3'd0);
            5'd13:   rom_line = uline(END,     OP_LOAD, 3'd0, 3'd0,  3'd0);
            default: rom_line = uline(NOP,     OP_LOAD, 3'd0, 3'd0,  3'd0);
        endcase
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            line_o <= '0;
        end else begin
            line_o <= rom_line;
        end
    end

endmodule

// ==== src/field_seq_ctrl.sv ====
//----------------------------------------------------------
// microprogram sequencer
// waits in idle for a command, then walks its program one
// line per step of at least STEP_CYCLES cycles, stalling
// while the arithmetic unit is busy. each line is decoded
// into a load, a field operation or a result capture
//----------------------------------------------------------
`timescale 1ns/1ps
`include "field_defs.svh"

module field_seq_ctrl (
    input  logic                     clk,
    input  logic                     reset_n,
    input  field_pkg::cmd_e          cmd_i,
    input  logic [`FIELD_W-1:0]      op_a_i,
    input  logic [`FIELD_W-1:0]      op_b_i,
    input  logic [`FIELD_W-1:0]      op_c_i,
    input  logic [`UPROG_LINE_W-1:0] line_i,
    input  logic                     busy_i,
    output logic [`UPROG_ADDR_W-1:0] pc_o,
    output logic                     start_o,
    output field_pkg::arith_op_e     op_o,
    output logic [`OPR_ADDR_W-1:0]   dst_o,
    output logic [`OPR_ADDR_W-1:0]   src_a_o,
    output logic [`OPR_ADDR_W-1:0]   src_b_o,
    output logic [`FIELD_W-1:0]      wr_data_o,
    output logic                     result_we_o,
    output logic                     seq_busy_o
);
    import field_pkg::*;

    localparam int CNT_W = $clog2(`STEP_CYCLES);
    localparam logic [CNT_W-1:0] CNT_END = CNT_W'(`STEP_CYCLES - 1);

    logic [CNT_W-1:0]       step_cnt;
    logic                   step_done;
    uop_e                   line_uop;
    arith_op_e              line_op;
    logic [`OPR_ADDR_W-1:0] line_dst;
    logic [`OPR_ADDR_W-1:0] line_sa;
    logic [`OPR_ADDR_W-1:0] line_sb;
    logic [`FIELD_W-1:0]    wr_mux;

    //----------------------------------------------------------
    // line decode
    //----------------------------------------------------------
    assign line_uop = uop_e'(line_i[LN_UOP +: 3]);
    assign line_op  = arith_op_e'(line_i[LN_OP +: 2]);
    assign line_dst = line_i[LN_DST +: `OPR_ADDR_W];
    assign line_sa  = line_i[LN_SA +: `OPR_ADDR_W];
    assign line_sb  = line_i[LN_SB +: `OPR_ADDR_W];

    // load source for WR_CORE lines
    always_comb begin
        case (src_e'(line_sa))
            SRC_A:   wr_mux = op_a_i;
            SRC_B:   wr_mux = op_b_i;
            SRC_C:   wr_mux = op_c_i;
            SRC_ONE: wr_mux = `FIELD_W'(1);
            default: wr_mux = '0;
        endcase
    end

    assign seq_busy_o = (pc_o != UPROG_IDLE);
    // line executes once paced out and not stalled
    assign step_done  = seq_busy_o && !busy_i && (step_cnt == CNT_END);

    //----------------------------------------------------------
    // program counter and pacing
    //----------------------------------------------------------
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            pc_o        <= UPROG_IDLE;
            step_cnt    <= '0;
            start_o     <= 1'b0;
            result_we_o <= 1'b0;
        end else begin
            start_o     <= 1'b0;
            result_we_o <= 1'b0;
            if (busy_i) begin
                step_cnt <= CNT_END;
            end else if (!seq_busy_o) begin
                step_cnt <= '0;
                case (cmd_i)
                    CMD_MULADD: pc_o <= MULADD_START;
                    CMD_SQRSUB: pc_o <= SQRSUB_START;
                    default:    pc_o <= UPROG_IDLE;
                endcase
            end else if (step_done) begin
                step_cnt    <= '0;
                pc_o        <= (line_uop == END) ? UPROG_IDLE : pc_o + 1'b1;
                start_o     <= (line_uop == WR_CORE) || (line_uop == ARITH);
                result_we_o <= (line_uop == RD_CORE);
            end else begin
                step_cnt <= step_cnt + 1'b1;
            end
        end
    end

    // operation fields, held until the next issue
    always_ff @(posedge clk) begin
        if (step_done) begin
            op_o      <= (line_uop == WR_CORE) ? OP_LOAD : line_op;
            dst_o     <= line_dst;
            src_a_o   <= line_sa;
            src_b_o   <= line_sb;
            wr_data_o <= wr_mux;
        end
    end

endmodule

// ==== src/field_arith_unit.sv ====
//----------------------------------------------------------
// arithmetic unit over GF(P), P = 2^32 - 5
// eight-word operand store; load, add and subtract complete
// in one cycle, multiply runs MSB-first double-and-add over
// 32 steps plus a write-back cycle
//----------------------------------------------------------
`timescale 1ns/1ps
`include "field_defs.svh"

module field_arith_unit (
    input  logic                   clk,
    input  logic                   reset_n,
    input  logic                   start_i,
    input  field_pkg::arith_op_e   op_i,
    input  logic [`OPR_ADDR_W-1:0] dst_i,
    input  logic [`OPR_ADDR_W-1:0] src_a_i,
    input  logic [`OPR_ADDR_W-1:0] src_b_i,
    input  logic [`FIELD_W-1:0]    wr_data_i,
    output logic [`FIELD_W-1:0]    rd_data_o,
    output logic                   busy_o
);
    import field_pkg::*;

    localparam logic [`FIELD_W-1:0] P = `FIELD_P;
    localparam int NREG   = 1 << `OPR_ADDR_W;
    localparam int MCNT_W = $clog2(`FIELD_W + 2);

    logic [`FIELD_W-1:0]    regs [NREG];
    logic [`FIELD_W-1:0]    opa;
    logic [`FIELD_W-1:0]    opb;
    logic [`FIELD_W-1:0]    mul_acc;
    logic [`FIELD_W-1:0]    mul_a;
    logic [`FIELD_W-1:0]    mul_b;
    logic [`FIELD_W-1:0]    mul_dbl;
    logic [`FIELD_W-1:0]    mul_step;
    logic [`OPR_ADDR_W-1:0] mul_dst;
    logic [MCNT_W-1:0]      mul_cnt;

    // x + y with one conditional subtract, valid for x + y < 2P
    function automatic logic [`FIELD_W-1:0] mod_add(
        input logic [`FIELD_W-1:0] x,
        input logic [`FIELD_W-1:0] y
    );
        logic [`FIELD_W:0] s;
        s = {1'b0, x} + {1'b0, y};
        if (s >= {1'b0, P}) begin
            s = s - {1'b0, P};
        end
        return s[`FIELD_W-1:0];
    endfunction

    // borrow is corrected by adding P back, wraps mod 2^32
    function automatic logic [`FIELD_W-1:0] mod_sub(
        input logic [`FIELD_W-1:0] x,
        input logic [`FIELD_W-1:0] y
    );
        return (x >= y) ? x - y : x - y + P;
    endfunction

    assign opa       = regs[src_a_i];
    assign opb       = regs[src_b_i];
    assign rd_data_o = opa;

    // acc = 2*acc + bit*a
    assign mul_dbl  = mod_add(mul_acc, mul_acc);
    assign mul_step = mul_b[`FIELD_W-1] ? mod_add(mul_dbl, mul_a) : mul_dbl;

    //----------------------------------------------------------
    // multiply control, 32 steps then write-back
    //----------------------------------------------------------
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            busy_o  <= 1'b0;
            mul_cnt <= '0;
        end else if (busy_o) begin
            busy_o  <= (mul_cnt != MCNT_W'(1));
            mul_cnt <= mul_cnt - 1'b1;
        end else if (start_i && op_i == OP_MUL) begin
            busy_o  <= 1'b1;
            mul_cnt <= MCNT_W'(`FIELD_W + 1);
        end
    end

    always_ff @(posedge clk) begin
        if (busy_o) begin
            if (mul_cnt == MCNT_W'(1)) begin
                regs[mul_dst] <= mul_acc;
            end else begin
                mul_acc <= mul_step;
                mul_b   <= mul_b << 1;
            end
        end else if (start_i) begin
            case (op_i)
                OP_LOAD: regs[dst_i] <= mod_add(wr_data_i, '0);
                OP_ADD:  regs[dst_i] <= mod_add(opa, opb);
                OP_SUB:  regs[dst_i] <= mod_sub(opa, opb);
                OP_MUL: begin
                    mul_acc <= '0;
                    mul_a   <= opa;
                    mul_b   <= opb;
                    mul_dst <= dst_i;
                end
                default: ;
            endcase
        end
    end

endmodule

// ==== src/field_axil_regs.sv ====
//----------------------------------------------------------
// AXI4-Lite register bank
// holds operands, command, status and result; a command is
// only taken while ready, and valid plus the done interrupt
// mark the end of each command
//----------------------------------------------------------
`timescale 1ns/1ps
`include "field_defs.svh"

module field_axil_regs (
    input  logic                clk,
    input  logic                reset_n,
    input  logic                awvalid_i,
    output logic                awready_o,
    input  logic [31:0]         awaddr_i,
    input  logic                wvalid_i,
    output logic                wready_o,
    input  logic [`FIELD_W-1:0] wdata_i,
    output logic                bvalid_o,
    input  logic                bready_i,
    output logic [1:0]          bresp_o,
    input  logic                arvalid_i,
    output logic                arready_o,
    input  logic [31:0]         araddr_i,
    output logic                rvalid_o,
    input  logic                rready_i,
    output logic [`FIELD_W-1:0] rdata_o,
    output logic [1:0]          rresp_o,
    input  logic                seq_busy_i,
    input  logic                arith_busy_i,
    input  logic                result_we_i,
    input  logic [`FIELD_W-1:0] result_i,
    output field_pkg::cmd_e     cmd_o,
    output logic [`FIELD_W-1:0] op_a_o,
    output logic [`FIELD_W-1:0] op_b_o,
    output logic [`FIELD_W-1:0] op_c_o,
    output logic                done_intr_o
);
    import field_pkg::*;

    logic                ready;
    logic                valid;
    logic                valid_d;
    logic                seq_busy_d;
    logic                wr_accept;
    logic                rd_accept;
    logic                op_we;
    logic                cmd_accept;
    logic [`FIELD_W-1:0] result_q;
    logic [`FIELD_W-1:0] rd_mux;

    assign ready = !seq_busy_i && !arith_busy_i;

    //----------------------------------------------------------
    // handshakes, address and data taken together
    //----------------------------------------------------------
    assign wr_accept = awvalid_i && wvalid_i && !bvalid_o;
    assign rd_accept = arvalid_i && !rvalid_o;
    assign awready_o = wr_accept;
    assign wready_o  = wr_accept;
    assign arready_o = rd_accept;
    assign bresp_o   = 2'b00;
    assign rresp_o   = 2'b00;

    assign op_we      = wr_accept && ready;
    assign cmd_accept = op_we && (awaddr_i == `REG_CTRL) &&
                        (wdata_i[1:0] == CMD_MULADD || wdata_i[1:0] == CMD_SQRSUB);

    // status: bit 0 ready, bit 1 valid
    always_comb begin
        case (araddr_i)
            `REG_NAME:   rd_mux = `CORE_NAME;
            `REG_STATUS: rd_mux = {{(`FIELD_W-2){1'b0}}, valid, ready};
            `REG_OP_A:   rd_mux = op_a_o;
            `REG_OP_B:   rd_mux = op_b_o;
            `REG_OP_C:   rd_mux = op_c_o;
            `REG_RESULT: rd_mux = result_q;
            default:     rd_mux = '0;
        endcase
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            bvalid_o   <= 1'b0;
            rvalid_o   <= 1'b0;
            cmd_o      <= CMD_NONE;
            op_a_o     <= '0;
            op_b_o     <= '0;
            op_c_o     <= '0;
            result_q   <= '0;
            valid      <= 1'b0;
            valid_d    <= 1'b0;
            seq_busy_d <= 1'b0;
        end else begin
            if (wr_accept) begin
                bvalid_o <= 1'b1;
            end else if (bready_i) begin
                bvalid_o <= 1'b0;
            end
            if (rd_accept) begin
                rvalid_o <= 1'b1;
            end else if (rready_i) begin
                rvalid_o <= 1'b0;
            end

            if (op_we && awaddr_i == `REG_OP_A) begin
                op_a_o <= wdata_i;
            end
            if (op_we && awaddr_i == `REG_OP_B) begin
                op_b_o <= wdata_i;
            end
            if (op_we && awaddr_i == `REG_OP_C) begin
                op_c_o <= wdata_i;
            end
            // one-cycle command pulse to the sequencer
            cmd_o <= cmd_accept ? cmd_e'(wdata_i[1:0]) : CMD_NONE;

            if (result_we_i) begin
                result_q <= result_i;
            end

            // falling edge of seq busy marks completion
            seq_busy_d <= seq_busy_i;
            if (seq_busy_d && !seq_busy_i) begin
                valid <= 1'b1;
            end
            if (cmd_accept) begin
                valid <= 1'b0;
            end
            valid_d <= valid;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_accept) begin
            rdata_o <= rd_mux;
        end
    end

    assign done_intr_o = valid && !valid_d;

endmodule

// ==== src/field_ctrl_top.sv ====
//----------------------------------------------------------
// prime-field controller top level
// software loads A, B and C, writes a command to CTRL and
// polls STATUS or waits for done_intr_o
//----------------------------------------------------------
`timescale 1ns/1ps
`include "field_defs.svh"

module field_ctrl_top (
    input  logic                clk,
    input  logic                reset_n,
    input  logic                awvalid_i,
    output logic                awready_o,
    input  logic [31:0]         awaddr_i,
    input  logic                wvalid_i,
    output logic                wready_o,
    input  logic [`FIELD_W-1:0] wdata_i,
    output logic                bvalid_o,
    input  logic                bready_i,
    output logic [1:0]          bresp_o,
    input  logic                arvalid_i,
    output logic                arready_o,
    input  logic [31:0]         araddr_i,
    output logic                rvalid_o,
    input  logic                rready_i,
    output logic [`FIELD_W-1:0] rdata_o,
    output logic [1:0]          rresp_o,
    output logic                done_intr_o
);
    import field_pkg::*;

    cmd_e                     cmd;
    arith_op_e                op;
    logic [`FIELD_W-1:0]      op_a;
    logic [`FIELD_W-1:0]      op_b;
    logic [`FIELD_W-1:0]      op_c;
    logic [`FIELD_W-1:0]      wr_data;
    logic [`FIELD_W-1:0]      rd_data;
    logic [`UPROG_ADDR_W-1:0] pc;
    logic [`UPROG_LINE_W-1:0] line;
    logic [`OPR_ADDR_W-1:0]   dst;
    logic [`OPR_ADDR_W-1:0]   src_a;
    logic [`OPR_ADDR_W-1:0]   src_b;
    logic                     start;
    logic                     arith_busy;
    logic                     seq_busy;
    logic                     result_we;

    field_axil_regs field_axil_regs_i (
        .clk, .reset_n,
        .awvalid_i, .awready_o, .awaddr_i, .wvalid_i, .wready_o, .wdata_i,
        .bvalid_o, .bready_i, .bresp_o,
        .arvalid_i, .arready_o, .araddr_i, .rvalid_o, .rready_i, .rdata_o, .rresp_o,
        .seq_busy_i(seq_busy), .arith_busy_i(arith_busy),
        .result_we_i(result_we), .result_i(rd_data),
        .cmd_o(cmd), .op_a_o(op_a), .op_b_o(op_b), .op_c_o(op_c),
        .done_intr_o
    );

    field_seq_ctrl field_seq_ctrl_i (
        .clk, .reset_n,
        .cmd_i(cmd), .op_a_i(op_a), .op_b_i(op_b), .op_c_i(op_c),
        .line_i(line), .busy_i(arith_busy),
        .pc_o(pc), .start_o(start), .op_o(op), .dst_o(dst),
        .src_a_o(src_a), .src_b_o(src_b), .wr_data_o(wr_data),
        .result_we_o(result_we), .seq_busy_o(seq_busy)
    );

    field_uprog_rom field_uprog_rom_i (
        .clk, .reset_n, .addr_i(pc), .line_o(line)
    );

    field_arith_unit field_arith_unit_i (
        .clk, .reset_n,
        .start_i(start), .op_i(op), .dst_i(dst),
        .src_a_i(src_a), .src_b_i(src_b), .wr_data_i(wr_data),
        .rd_data_o(rd_data), .busy_o(arith_busy)
    );

endmodule

// ==== sim/field_ctrl_asserts.sv ====
//----------------------------------------------------------
// protocol assertions for the prime-field controller
// bound to the top level; checks response hold under
// back-pressure, one done pulse per command and the ready
// bit of STATUS while a command runs
//----------------------------------------------------------
`timescale 1ns/1ps
`include "field_defs.svh"

module field_ctrl_asserts (
    input logic                clk,
    input logic                reset_n,
    input logic                bvalid_i,
    input logic                bready_i,
    input logic                arvalid_i,
    input logic                arready_i,
    input logic [31:0]         araddr_i,
    input logic                rvalid_i,
    input logic                rready_i,
    input logic [`FIELD_W-1:0] rdata_i,
    input logic                done_intr_i,
    input logic                seq_busy_i
);

    logic armed;
    int   fail_cnt = 0;

    // armed from a running command until its done pulse
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            armed <= 1'b0;
        end else if (seq_busy_i) begin
            armed <= 1'b1;
        end else if (done_intr_i) begin
            armed <= 1'b0;
        end
    end

    // write response held until taken
    bvalid_hold: assert property (@(posedge clk) disable iff (!reset_n)
        bvalid_i && !bready_i |=> bvalid_i)
        else begin
            $error("bvalid dropped before bready");
            fail_cnt++;
        end

    // read response and data held until taken
    rvalid_hold: assert property (@(posedge clk) disable iff (!reset_n)
        rvalid_i && !rready_i |=> rvalid_i && $stable(rdata_i))
        else begin
            $error("rvalid or rdata changed before rready");
            fail_cnt++;
        end

    // one single-cycle pulse per finished command
    done_once: assert property (@(posedge clk) disable iff (!reset_n)
        done_intr_i |-> armed)
        else begin
            $error("done interrupt without a finished command");
            fail_cnt++;
        end

    status_busy: assert property (@(posedge clk) disable iff (!reset_n)
        arvalid_i && arready_i && araddr_i == `REG_STATUS && seq_busy_i
        |=> !rdata_i[0])
        else begin
            $error("status read shows ready while a command runs");
            fail_cnt++;
        end

endmodule

bind field_ctrl_top field_ctrl_asserts field_ctrl_asserts_i (
    .clk         (clk),
    .reset_n     (reset_n),
    .bvalid_i    (bvalid_o),
    .bready_i    (bready_i),
    .arvalid_i   (arvalid_i),
    .arready_i   (arready_o),
    .araddr_i    (araddr_i),
    .rvalid_i    (rvalid_o),
    .rready_i    (rready_i),
    .rdata_i     (rdata_o),
    .done_intr_i (done_intr_o),
    .seq_busy_i  (seq_busy)
);

// ==== sim/tb_field_ctrl.sv ====
//----------------------------------------------------------
// testbench for the prime-field controller
// drives AXI4-Lite on the falling edge, runs MULADD and
// SQRSUB against a 64-bit reference model, and checks the
// register map, done interrupt and back-pressure behavior
//----------------------------------------------------------
`timescale 1ns/1ps
`include "field_defs.svh"

module tb_field_ctrl;
    import field_pkg::*;

    localparam int N_CMDS      = 41;
    localparam int CYCLE_LIMIT = 200 * N_CMDS + 1000;
    localparam logic [31:0] P  = `FIELD_P;

    logic        clk = 1'b0;
    logic        reset_n;
    logic        awvalid;
    logic        awready;
    logic [31:0] awaddr;
    logic        wvalid;
    logic        wready;
    logic [31:0] wdata;
    logic        bvalid;
    logic        bready;
    logic [1:0]  bresp;
    logic        arvalid;
    logic        arready;
    logic [31:0] araddr;
    logic        rvalid;
    logic        rready;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic        done_intr;

    int          n_errors = 0;
    int          n_tests = 0;
    int          done_cnt = 0;
    int          cycles = 0;
    string       name_q[$];
    logic [31:0] exp_q[$];
    logic [31:0] act_q[$];

    field_ctrl_top field_ctrl_top_i (
        .clk, .reset_n,
        .awvalid_i(awvalid), .awready_o(awready), .awaddr_i(awaddr),
        .wvalid_i(wvalid), .wready_o(wready), .wdata_i(wdata),
        .bvalid_o(bvalid), .bready_i(bready), .bresp_o(bresp),
        .arvalid_i(arvalid), .arready_o(arready), .araddr_i(araddr),
        .rvalid_o(rvalid), .rready_i(rready), .rdata_o(rdata), .rresp_o(rresp),
        .done_intr_o(done_intr)
    );

    always #4 clk = ~clk;

    // run limit
    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout, run still busy after %0d cycles", cycles);
            $display("=== FAIL ===");
            $finish;
        end
    end

    always @(negedge clk) begin
        if (reset_n && done_intr) begin
            done_cnt++;
        end
    end

    // expected result with every term reduced mod P in 64 bits
    function automatic logic [31:0] ref_field(input cmd_e cmd, input logic [31:0] a,
                                              input logic [31:0] b, input logic [31:0] c);
        logic [63:0] p;
        logic [63:0] ra;
        logic [63:0] rb;
        logic [63:0] rc;
        logic [63:0] t;
        p  = {32'h0, P};
        ra = {32'h0, a} % p;
        rb = {32'h0, b} % p;
        rc = {32'h0, c} % p;
        if (cmd == CMD_MULADD) begin
            t = ((ra * rb) % p + rc) % p;
        end else begin
            t = ((ra * ra) % p + p - rb) % p;
        end
        return t[31:0];
    endfunction

    task automatic check_word(input string name, input logic [31:0] exp_v,
                              input logic [31:0] act_v);
        if (act_v !== exp_v) begin
            $display("Error: %s expected %08h actual %08h", name, exp_v, act_v);
            n_errors++;
        end
    endtask

    task automatic check_flag(input string what, input logic ok);
        if (!ok) begin
            $display("%s", what);
            n_errors++;
        end
    endtask

    task automatic finish_test(input string name, input int err_start);
        n_tests++;
        $display("test %s finished with %0d errors", name, n_errors - err_start);
    endtask

    //----------------------------------------------------------
    // AXI4-Lite accesses with valid held until accepted
    //----------------------------------------------------------
    task automatic write_reg(input logic [31:0] addr, input logic [31:0] data);
        @(negedge clk);
        awvalid = 1'b1;
        wvalid  = 1'b1;
        awaddr  = addr;
        wdata   = data;
        bready  = 1'b1;
        do @(posedge clk); while (!(awready && wready));
        @(negedge clk);
        awvalid = 1'b0;
        wvalid  = 1'b0;
        do @(posedge clk); while (!bvalid);
        check_flag("write response was not OKAY", bresp == 2'b00);
    endtask

    task automatic read_reg(input logic [31:0] addr, output logic [31:0] data);
        @(negedge clk);
        arvalid = 1'b1;
        araddr  = addr;
        rready  = 1'b1;
        do @(posedge clk); while (!arready);
        @(negedge clk);
        arvalid = 1'b0;
        do @(posedge clk); while (!rvalid);
        data = rdata;
        check_flag("read response was not OKAY", rresp == 2'b00);
    endtask

    // runs one command and writes new operands meanwhile if disturb is set
    task automatic run_cmd(input string name, input cmd_e cmd, input logic [31:0] a,
                           input logic [31:0] b, input logic [31:0] c, input logic disturb);
        logic [31:0] status;
        logic [31:0] result;
        int          done_before;
        done_before = done_cnt;
        write_reg(`REG_OP_A, a);
        write_reg(`REG_OP_B, b);
        write_reg(`REG_OP_C, c);
        write_reg(`REG_CTRL, 32'(cmd));
        // valid cleared and ready low once accepted
        read_reg(`REG_STATUS, status);
        check_word({name, " status after start"}, 32'h0, status);
        if (disturb) begin
            write_reg(`REG_OP_A, ~a);
            write_reg(`REG_OP_B, a ^ b);
        end
        do @(negedge clk); while (!done_intr);
        read_reg(`REG_RESULT, result);
        name_q.push_back(name);
        exp_q.push_back(ref_field(cmd, a, b, c));
        act_q.push_back(result);
        read_reg(`REG_STATUS, status);
        check_word({name, " status at end"}, 32'h3, status);
        check_word({name, " done pulses"}, 32'(done_before + 1), 32'(done_cnt));
        if (disturb) begin
            read_reg(`REG_OP_A, status);
            check_word({name, " operand A"}, a, status);
        end
    endtask

    always begin : compare_results
        string       name;
        logic [31:0] exp_v;
        logic [31:0] act_v;
        wait (act_q.size() != 0);
        name  = name_q.pop_front();
        exp_v = exp_q.pop_front();
        act_v = act_q.pop_front();
        n_tests++;
        if (act_v !== exp_v) begin
            $display("Error: %s expected %08h actual %08h", name, exp_v, act_v);
            n_errors++;
        end else begin
            $display("test %s passed, result %08h", name, act_v);
        end
    end

    //----------------------------------------------------------
    // stimulus
    //----------------------------------------------------------
    initial begin
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        logic [31:0] data;
        int          err_start;
        void'($urandom(32'hdd342224));
        reset_n = 1'b0;
        awvalid = 1'b0;
        awaddr  = '0;
        wvalid  = 1'b0;
        wdata   = '0;
        bready  = 1'b0;
        arvalid = 1'b0;
        araddr  = '0;
        rready  = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset_n = 1'b1;

        err_start = n_errors;
        read_reg(`REG_NAME, data);
        check_word("reset name", `CORE_NAME, data);
        read_reg(`REG_STATUS, data);
        check_word("reset status", 32'h1, data);
        read_reg(`REG_RESULT, data);
        check_word("reset result", 32'h0, data);
        finish_test("reset", err_start);

        for (int i = 0; i < 20; i++) begin
            a = $urandom();
            b = $urandom();
            c = $urandom();
            // values at or above P
            if (i % 4 == 0) a = P + 32'(i % 5);
            if (i % 4 == 1) b = 32'hFFFFFFFF;
            if (i % 4 == 3) c = P + 32'h1;
            run_cmd($sformatf("muladd_%0d", i), CMD_MULADD, a, b, c, 1'b0);
        end

        for (int i = 0; i < 20; i++) begin
            a = $urandom();
            b = $urandom();
            c = $urandom();
            if (i % 4 == 0) a = P + 32'(i % 5);
            if (i % 4 == 2) b = 32'hFFFFFFFE;
            // small square with B above it so the result wraps
            if (i % 2 == 1) begin
                a = $urandom() & 32'h0000FFFF;
                b = P - 32'h1 - 32'(i);
            end
            run_cmd($sformatf("sqrsub_%0d", i), CMD_SQRSUB, a, b, c, 1'b0);
        end

        run_cmd("operand_write_while_busy", CMD_MULADD, $urandom(), $urandom(),
                $urandom(), 1'b1);

        // read back-pressure with a second request held on the bus
        err_start = n_errors;
        @(negedge clk);
        arvalid = 1'b1;
        araddr  = `REG_NAME;
        rready  = 1'b0;
        do @(posedge clk); while (!arready);
        repeat (5) begin
            @(negedge clk);
            araddr = `REG_RESULT;
            check_flag("rvalid dropped under back-pressure", rvalid);
            check_flag("read accepted while response pending", !arready);
            check_word("read back-pressure data", `CORE_NAME, rdata);
        end
        arvalid = 1'b0;
        rready  = 1'b1;
        @(posedge clk);
        @(negedge clk);
        check_flag("rvalid still high after rready", !rvalid);

        // write back-pressure where the changed data must not land
        a = $urandom();
        @(negedge clk);
        awvalid = 1'b1;
        wvalid  = 1'b1;
        awaddr  = `REG_OP_C;
        wdata   = a;
        bready  = 1'b0;
        do @(posedge clk); while (!(awready && wready));
        repeat (5) begin
            @(negedge clk);
            wdata = ~a;
            check_flag("bvalid dropped under back-pressure", bvalid);
            check_flag("write accepted while response pending", !awready && !wready);
        end
        awvalid = 1'b0;
        wvalid  = 1'b0;
        bready  = 1'b1;
        @(posedge clk);
        @(negedge clk);
        check_flag("bvalid still high after bready", !bvalid);
        read_reg(`REG_OP_C, data);
        check_word("write back-pressure data", a, data);
        finish_test("back_pressure", err_start);

        wait (act_q.size() == 0);
        @(negedge clk);
        check_word("total done pulses", 32'(N_CMDS), 32'(done_cnt));
        if (field_ctrl_top_i.field_ctrl_asserts_i.fail_cnt != 0) begin
            $display("protocol assertions failed %0d times",
                     field_ctrl_top_i.field_ctrl_asserts_i.fail_cnt);
            n_errors++;
        end
        $display("%0d tests run, %0d errors", n_tests, n_errors);
        if (n_errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+src
src/field_pkg.sv
src/field_uprog_rom.sv
src/field_seq_ctrl.sv
src/field_arith_unit.sv
src/field_axil_regs.sv
src/field_ctrl_top.sv
sim/field_ctrl_asserts.sv
sim/tb_field_ctrl.sv
